/* logic/intl_pkg.sv */
`default_nettype none

package intl_pkg;

    // -------------------------------------------------------------------
    // widths
    // -------------------------------------------------------------------
    localparam int SYM_W   = 2;     // one two-bit symbol
    localparam int ADDR_W  = 12;    // linear block address
    localparam int LOCAL_W = 10;    // address inside one bank, depth 1024
    localparam int LANES   = 4;     // banks and output lanes

    // position step inside a quarter
    // odd and coprime with 16, 136 and 520
    localparam int STRIDE = 7;

    // -------------------------------------------------------------------
    // block lengths in symbols
    // -------------------------------------------------------------------
    localparam logic [11:0] PB_LEN_16  = 12'd64;
    localparam logic [11:0] PB_LEN_136 = 12'd544;
    localparam logic [11:0] PB_LEN_520 = 12'd2080;

    // size class of a block
    typedef enum logic [1:0] {
        PB_16,
        PB_136,
        PB_520,
        PB_NONE
    } pb_size_e;

    // read sequencer state
    typedef enum logic {
        IDLE,
        READ
    } seq_state_e;

endpackage

`default_nettype wire

/* logic/pb_size_decode.sv */
`timescale 1ns/10ps
`default_nettype none

module pb_size_decode #(
    parameter int addr_w = intl_pkg::ADDR_W
) (
    input  wire  [addr_w-1:0]               pb_len,
    input  wire  [addr_w-1:0]               waddr,
    input  wire                             wen,
    output intl_pkg::pb_size_e              size_class,
    output logic [intl_pkg::LOCAL_W-1:0]    quarter_len,
    output logic                            wr_en,
    output logic [1:0]                      wr_bank,
    output logic [intl_pkg::LOCAL_W-1:0]    wr_local
);
    import intl_pkg::*;

    logic [addr_w-1:0] qtr;       // quarter boundaries at block address width
    logic [addr_w-1:0] half;
    logic [addr_w-1:0] three_q;
    logic [addr_w-1:0] base;
    logic [addr_w-1:0] offset;

    always_comb begin
        if (pb_len == addr_w'(PB_LEN_16)) begin
            size_class  = PB_16;
            quarter_len = LOCAL_W'(PB_LEN_16 >> 2);
        end else if (pb_len == addr_w'(PB_LEN_136)) begin
            size_class  = PB_136;
            quarter_len = LOCAL_W'(PB_LEN_136 >> 2);
        end else if (pb_len == addr_w'(PB_LEN_520)) begin
            size_class  = PB_520;
            quarter_len = LOCAL_W'(PB_LEN_520 >> 2);
        end else begin
            size_class  = PB_NONE;
            quarter_len = '0;
        end
    end

    assign qtr     = addr_w'(quarter_len);
    assign half    = qtr << 1;
    assign three_q = qtr + half;

    // which quarter holds waddr
    always_comb begin
        if (waddr < qtr) begin
            wr_bank = 2'd0;
            base    = '0;
        end else if (waddr < half) begin
            wr_bank = 2'd1;
            base    = qtr;
        end else if (waddr < three_q) begin
            wr_bank = 2'd2;
            base    = half;
        end else begin
            wr_bank = 2'd3;
            base    = three_q;
        end
    end

    assign offset   = waddr - base;
    assign wr_local = offset[LOCAL_W-1:0];
    assign wr_en    = wen && (size_class != PB_NONE) && (waddr < pb_len); // drop out-of-block

endmodule

`default_nettype wire

/* logic/symbol_banks.sv */
`timescale 1ns/10ps
`default_nettype none

module symbol_banks #(
    parameter int sym_w = intl_pkg::SYM_W
) (
    input  wire                                         clk,
    input  wire                                         wr_en,
    input  wire  [1:0]                                  wr_bank,
    input  wire  [intl_pkg::LOCAL_W-1:0]                wr_local,
    input  wire  [sym_w-1:0]                            wdata,
    input  wire                                         rd_en,
    input  wire  [intl_pkg::LOCAL_W-1:0]                rd_pos,
    output logic [intl_pkg::LANES*sym_w-1:0]            bank_rdata
);
    import intl_pkg::*;

    localparam int DEPTH = 2 ** LOCAL_W;

    // -------------------------------------------------------------------
    // one memory per quarter, shared write port
    // -------------------------------------------------------------------
    for (genvar b = 0; b < LANES; b++) begin : g_bank
        logic [sym_w-1:0] mem [0:DEPTH-1];
        logic [sym_w-1:0] rd_q;

        always_ff @(posedge clk) begin
            if (wr_en && (wr_bank == 2'(b))) begin
                mem[wr_local] <= wdata;
            end
        end

        // every bank reads the same local position
        always_ff @(posedge clk) begin
            if (rd_en) begin
                rd_q <= mem[rd_pos];
            end
        end

        assign bank_rdata[b*sym_w +: sym_w] = rd_q;
    end

    // writes stay inside the largest quarter
    a_wr_in_bank: assert property (@(posedge clk)
        wr_en |-> (wr_local < LOCAL_W'(PB_LEN_520 >> 2)));

endmodule

`default_nettype wire

/* logic/read_sequencer.sv */
`timescale 1ns/10ps
`default_nettype none

module read_sequencer #(
    parameter int stride = intl_pkg::STRIDE
) (
    input  wire                             clk,
    input  wire                             n_rst,
    input  wire                             start,
    input  wire  intl_pkg::pb_size_e        size_class,
    input  wire  [intl_pkg::LOCAL_W-1:0]    quarter_len,
    output logic                            rd_en,
    output logic [intl_pkg::LOCAL_W-1:0]    rd_pos,
    output logic [1:0]                      rd_rot
);
    import intl_pkg::*;

    seq_state_e             state;
    logic [LOCAL_W-1:0]     q_len;      // latched on accepted start
    logic [LOCAL_W-1:0]     step;
    logic [LOCAL_W-1:0]     pos;
    logic [1:0]             rot;
    logic [LOCAL_W:0]       pos_sum;
    logic [LOCAL_W-1:0]     pos_next;
    logic                   accept;
    logic                   last;

    assign accept  = (state == IDLE) && start && (size_class != PB_NONE);
    assign last    = (step == q_len - LOCAL_W'(1));

    // position modulo Q, stride is below every quarter length
    assign pos_sum  = {1'b0, pos} + (LOCAL_W+1)'(stride);
    assign pos_next = (pos_sum >= {1'b0, q_len}) ? LOCAL_W'(pos_sum - {1'b0, q_len})
                                                 : pos_sum[LOCAL_W-1:0];

    always_ff @(posedge clk or negedge n_rst) begin
        if (!n_rst) begin
            state <= IDLE;
            q_len <= '0;
            step  <= '0;
            pos   <= '0;
            rot   <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (accept) begin
                        state <= READ;
                        q_len <= quarter_len;
                        step  <= '0;
                        pos   <= '0;
                        rot   <= '0;
                    end
                end
                READ: begin             // start ignored here
                    step <= step + LOCAL_W'(1);
                    pos  <= pos_next;
                    rot  <= rot + 2'd1;
                    if (last) begin
                        state <= IDLE;
                    end
                end
            endcase
        end
    end

    // step issued one cycle behind the state
    always_ff @(posedge clk or negedge n_rst) begin
        if (!n_rst) begin
            rd_en  <= 1'b0;
            rd_pos <= '0;
            rd_rot <= '0;
        end else begin
            rd_en <= (state == READ);
            if (state == READ) begin
                rd_pos <= pos;
                rd_rot <= rot;
            end
        end
    end

    a_pos_below_q: assert property (@(posedge clk) disable iff (!n_rst)
        rd_en |-> (rd_pos < q_len));

    // only the final step may trail out of READ
    a_rd_en_in_read: assert property (@(posedge clk) disable iff (!n_rst)
        rd_en |-> ((state == READ) || $past(last)));

endmodule

`default_nettype wire

/* logic/lane_rotator.sv */
`timescale 1ns/10ps
`default_nettype none

module lane_rotator #(
    parameter int sym_w = intl_pkg::SYM_W
) (
    input  wire                                 clk,
    input  wire                                 n_rst,
    input  wire                                 rd_en,
    input  wire  [1:0]                          rd_rot,
    input  wire  [intl_pkg::LANES*sym_w-1:0]    bank_rdata,
    output logic [sym_w-1:0]                    rdata0,
    output logic [sym_w-1:0]                    rdata1,
    output logic [sym_w-1:0]                    rdata2,
    output logic [sym_w-1:0]                    rdata3,
    output logic                                dout_vld
);
    import intl_pkg::*;

    logic               vld_d;          // lines up with bank data
    logic [1:0]         rot_d;
    logic [sym_w-1:0]   lane [LANES];

    always_ff @(posedge clk or negedge n_rst) begin
        if (!n_rst) begin
            vld_d <= 1'b0;
            rot_d <= '0;
        end else begin
            vld_d <= rd_en;
            rot_d <= rd_rot;
        end
    end

    // lane j takes bank (j + rot) mod 4
    always_comb begin
        logic [1:0] sel;
        for (int j = 0; j < LANES; j++) begin
            sel     = 2'(j) + rot_d;
            lane[j] = bank_rdata[sel*sym_w +: sym_w];
        end
    end

    always_ff @(posedge clk or negedge n_rst) begin
        if (!n_rst) begin
            rdata0   <= '0;
            rdata1   <= '0;
            rdata2   <= '0;
            rdata3   <= '0;
            dout_vld <= 1'b0;
        end else begin
            dout_vld <= vld_d;
            if (vld_d) begin            // hold otherwise
                rdata0 <= lane[0];
                rdata1 <= lane[1];
                rdata2 <= lane[2];
                rdata3 <= lane[3];
            end
        end
    end

endmodule

`default_nettype wire

/* logic/intl_top.sv */
`timescale 1ns/10ps
`default_nettype none

module intl_top #(
    parameter int sym_w  = intl_pkg::SYM_W,
    parameter int addr_w = intl_pkg::ADDR_W,
    parameter int stride = intl_pkg::STRIDE
) (
    input  wire                 clk,
    input  wire                 n_rst,
    input  wire  [sym_w-1:0]    wdata,
    input  wire  [addr_w-1:0]   waddr,
    input  wire                 wen,
    input  wire  [addr_w-1:0]   pb_len,   // held still while a block is written
    input  wire                 start,
    output logic [sym_w-1:0]    rdata0,
    output logic [sym_w-1:0]    rdata1,
    output logic [sym_w-1:0]    rdata2,
    output logic [sym_w-1:0]    rdata3,
    output logic                dout_vld
);
    import intl_pkg::*;

    pb_size_e                   size_class;
    logic [LOCAL_W-1:0]         quarter_len;
    logic                       wr_en;
    logic [1:0]                 wr_bank;
    logic [LOCAL_W-1:0]         wr_local;
    logic                       rd_en;
    logic [LOCAL_W-1:0]         rd_pos;
    logic [1:0]                 rd_rot;
    logic [LANES*sym_w-1:0]     bank_rdata;

    pb_size_decode #(
        .addr_w      (addr_w)
    ) u_decode (
        .pb_len      (pb_len),
        .waddr       (waddr),
        .wen         (wen),
        .size_class  (size_class),
        .quarter_len (quarter_len),
        .wr_en       (wr_en),
        .wr_bank     (wr_bank),
        .wr_local    (wr_local)
    );

    symbol_banks #(
        .sym_w      (sym_w)
    ) u_banks (
        .clk        (clk),
        .wr_en      (wr_en),
        .wr_bank    (wr_bank),
        .wr_local   (wr_local),
        .wdata      (wdata),
        .rd_en      (rd_en),
        .rd_pos     (rd_pos),
        .bank_rdata (bank_rdata)
    );

    read_sequencer #(
        .stride      (stride)
    ) u_seq (
        .clk         (clk),
        .n_rst       (n_rst),
        .start       (start),
        .size_class  (size_class),
        .quarter_len (quarter_len),
        .rd_en       (rd_en),
        .rd_pos      (rd_pos),
        .rd_rot      (rd_rot)
    );

    lane_rotator #(
        .sym_w      (sym_w)
    ) u_rot (
        .clk        (clk),
        .n_rst      (n_rst),
        .rd_en      (rd_en),
        .rd_rot     (rd_rot),
        .bank_rdata (bank_rdata),
        .rdata0     (rdata0),
        .rdata1     (rdata1),
        .rdata2     (rdata2),
        .rdata3     (rdata3),
        .dout_vld   (dout_vld)
    );

endmodule

`default_nettype wire

/* testbench/tb_intl.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_intl;
    import intl_pkg::*;

    localparam int MAX_TESTS  = 32;
    localparam int RST_CYCLES = 16;
    localparam int NONE_WAIT  = 2 * 520;
    localparam int EXTRA_WR   = 8;        // writes past the block end

    logic               clk;
    logic               n_rst;
    logic [SYM_W-1:0]   wdata;
    logic [ADDR_W-1:0]  waddr;
    logic               wen;
    logic [ADDR_W-1:0]  pb_len;
    logic               start;
    logic [SYM_W-1:0]   rdata0;
    logic [SYM_W-1:0]   rdata1;
    logic [SYM_W-1:0]   rdata2;
    logic [SYM_W-1:0]   rdata3;
    logic               dout_vld;

    logic [15:0]        tests_mem [0:3*MAX_TESTS-1];
    logic [SYM_W-1:0]   model_mem [0:2**ADDR_W-1];   // symbols as written
    logic [31:0]        lfsr;
    int                 num_tests;
    int                 cycle_limit = 1000000;
    int                 cycles = 0;
    int                 errors;
    int                 passed;
    int                 failed;

    intl_top u_intl_top (
        .clk      (clk),
        .n_rst    (n_rst),
        .wdata    (wdata),
        .waddr    (waddr),
        .wen      (wen),
        .pb_len   (pb_len),
        .start    (start),
        .rdata0   (rdata0),
        .rdata1   (rdata1),
        .rdata2   (rdata2),
        .rdata3   (rdata3),
        .dout_vld (dout_vld)
    );

    initial clk = 1'b0;
    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("timeout: run did not finish within %0d cycles", cycle_limit);
            $display("tests failed");
            $finish;
        end
    end

    // -------------------------------------------------------------------
    // random data and checks
    // -------------------------------------------------------------------
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];   // x^32 + x^22 + x^2 + x + 1
        return {s[30:0], fb};
    endfunction

    task automatic take_bits(input int n, output logic [11:0] value);
        value = '0;
        for (int i = 0; i < n; i++) begin
            lfsr  = lfsr_next(lfsr);
            value = {value[10:0], lfsr[0]};
        end
    endtask

    function automatic logic [SYM_W-1:0] lane_value(input int j);
        case (j)
            0:       return rdata0;
            1:       return rdata1;
            2:       return rdata2;
            default: return rdata3;
        endcase
    endfunction

    task automatic check_sym(input string name, input logic [SYM_W-1:0] got,
                             input logic [SYM_W-1:0] exp);
        if (got !== exp) begin
            $display("FAIL %0t %s got %0h expected %0h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic check_cnt(input string name, input int got, input int exp);
        if (got != exp) begin
            $display("FAIL %0t %s got %0d expected %0d", $time, name, got, exp);
            errors++;
        end
    endtask

    // -------------------------------------------------------------------
    // stimulus
    // -------------------------------------------------------------------
    task automatic write_block(input int len);
        logic [11:0] bits;
        for (int a = 0; a < len; a++) begin
            take_bits(SYM_W, bits);
            @(posedge clk);
            wen   <= 1'b1;
            waddr <= ADDR_W'(a);
            wdata <= bits[SYM_W-1:0];
            model_mem[a] = bits[SYM_W-1:0];
        end
        @(posedge clk);
        wen <= 1'b0;
    endtask

    task automatic write_outside(input int len);
        logic [11:0] bits;
        int          q;
        int          k;
        q = len / LANES;
        for (int i = 0; i < EXTRA_WR; i++) begin
            take_bits(12, bits);
            k = int'(bits) % q;
            @(posedge clk);
            wen   <= 1'b1;
            // past the block, yet the bank address would wrap onto the last quarter
            waddr <= (i == 0) ? ADDR_W'(len) : ADDR_W'(3 * q + (2 ** LOCAL_W) + k);
            wdata <= ~model_mem[3 * q + k];
        end
        @(posedge clk);
        wen <= 1'b0;
    endtask

    task automatic pulse_start();
        @(posedge clk);
        start <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
    endtask

    task automatic read_and_check(input int len);
        int q;
        int latency;
        int run;
        int extra;
        int p;
        int r;
        q = len / LANES;
        pulse_start();
        latency = 0;
        while (latency < 16) begin
            @(posedge clk);
            latency++;
            @(negedge clk);
            if (dout_vld) break;
        end
        if (!dout_vld) begin
            $display("no dout_vld seen after an accepted start");
            errors++;
            return;
        end
        check_cnt("dout_vld latency", latency, 3);
        run = 0;
        while (dout_vld && run < q + 8) begin
            if (run < q) begin
                p = (run * STRIDE) % q;
                for (int j = 0; j < LANES; j++) begin
                    r = (j + run) % LANES;
                    check_sym($sformatf("rdata%0d step %0d", j, run), lane_value(j),
                              model_mem[r*q+p]);
                end
            end
            @(posedge clk);
            start <= (run == q / 2);   // extra start mid-read
            run++;
            @(negedge clk);
        end
        check_cnt("dout_vld run length", run, q);
        extra = 0;
        @(posedge clk);
        start <= 1'b0;
        repeat (8) begin
            @(negedge clk);
            if (dout_vld) extra++;
        end
        check_cnt("dout_vld after run", extra, 0);
    endtask

    task automatic expect_no_output();
        int seen;
        seen = 0;
        pulse_start();
        repeat (NONE_WAIT) begin
            @(negedge clk);
            if (dout_vld) seen++;
        end
        check_cnt("dout_vld for unsupported pb_len", seen, 0);
    endtask

    // -------------------------------------------------------------------
    // main sequence
    // -------------------------------------------------------------------
    initial begin
        int len;
        int accepted;
        int advance;
        int err_before;
        int settle_vld;
        n_rst  = 1'b0;
        wdata  = '0;
        waddr  = '0;
        wen    = 1'b0;
        pb_len = '0;
        start  = 1'b0;
        errors = 0;
        passed = 0;
        failed = 0;
        lfsr   = 32'h136e_94e4;
        for (int i = 0; i < 3 * MAX_TESTS; i++) begin
            tests_mem[i] = '0;
        end
        $readmemh("testbench/intl_tests.txt", tests_mem);
        num_tests   = 0;
        cycle_limit = RST_CYCLES + 16;
        while (num_tests < MAX_TESTS && tests_mem[3*num_tests] != '0) begin
            cycle_limit += 2 * int'(tests_mem[3*num_tests]) + 40;
            num_tests++;
        end
        if (num_tests == 0) begin
            $display("no tests found in testbench/intl_tests.txt");
            errors++;
        end

        repeat (RST_CYCLES) @(posedge clk);
        n_rst <= 1'b1;

        // idle outputs after reset
        err_before = errors;
        settle_vld = 0;
        repeat (8) begin
            @(negedge clk);
            if (dout_vld) settle_vld++;
            for (int j = 0; j < LANES; j++) begin
                check_sym($sformatf("rdata%0d after reset", j), lane_value(j), '0);
            end
        end
        check_cnt("dout_vld after reset", settle_vld, 0);
        if (errors == err_before) begin
            passed++;
            $display("test 0 reset: ok");
        end else begin
            failed++;
            $display("test 0 reset: %0d errors", errors - err_before);
        end

        for (int t = 0; t < num_tests; t++) begin
            len        = int'(tests_mem[3*t]);
            accepted   = int'(tests_mem[3*t+1]);
            advance    = int'(tests_mem[3*t+2]);
            err_before = errors;
            repeat (advance) lfsr = lfsr_next(lfsr);
            @(posedge clk);
            pb_len <= ADDR_W'(len);
            if (accepted != 0) begin
                write_block(len);
                write_outside(len);
                read_and_check(len);
            end else begin
                expect_no_output();
            end
            if (errors == err_before) begin
                passed++;
                $display("test %0d pb_len %0d: ok", t + 1, len);
            end else begin
                failed++;
                $display("test %0d pb_len %0d: %0d errors", t + 1, len, errors - err_before);
            end
        end

        $display("tests %0d, passed %0d, failed %0d", passed + failed, passed, failed);
        if (errors == 0 && failed == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* testbench/intl_tests.txt */
// columns: pb_len (symbols, hex)  start accepted (1/0)  extra lfsr steps (hex)
// supported pb_len values are 040, 220 and 820
040 1 0
220 1 3
820 1 11
123 0 0
040 1 5
800 0 2
820 1 1f
220 1 7
040 1 2

/* tb.f */
logic/intl_pkg.sv
logic/pb_size_decode.sv
logic/symbol_banks.sv
logic/read_sequencer.sv
logic/lane_rotator.sv
logic/intl_top.sv
testbench/tb_intl.sv

/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --timing --assert --timescale 1ns/10ps --top-module tb_intl \
		-f tb.f -o tb_intl_sim
	out=$$(./obj_dir/tb_intl_sim); echo "$$out"; \
		echo "$$out" | grep -q "^all tests passed$$"

clean:
	rm -rf obj_dir
